//--- compile.f
common/sm_core_pkg.sv
common/sm_isa_pkg.sv
src/sm_ram.sv
sequencer/sm_sequencer.sv
execute/sm_execute.sv
src/sm_port_unit.sv
src/sm_core.sv
sim/sm_checker.sv
sim/tb_sm_core.sv

//--- Bender.yml
package:
  name: sm_core

sources:
  # Packages first, the RTL uses them by scoped names
  - common/sm_core_pkg.sv
  - common/sm_isa_pkg.sv
  # Design
  - src/sm_ram.sv
  - sequencer/sm_sequencer.sv
  - execute/sm_execute.sv
  - src/sm_port_unit.sv
  - src/sm_core.sv
  # Testbench
  - target: simulation
    files:
      - sim/sm_checker.sv
      - sim/tb_sm_core.sv

//--- sim/tb_sm_core.sv
`timescale 1ns/1ns

module tb_sm_core;

  logic                            clk;
  logic                            reset;
  logic                            clk_en;
  sm_core_pkg::opcode_t            rom_data;
  sm_core_pkg::pc_t                rom_addr;
  sm_core_pkg::nibble_t            input_k;
  logic [sm_core_pkg::W_WIDTH-1:0] output_shifter_s;
  sm_core_pkg::nibble_t            segment_l;

  sm_core_pkg::opcode_t rom [4096];

  integer seed;
  integer en_seed = 51546;
  sm_core_pkg::pc_t org;
  int  n_instr;
  int  tests_run;
  int  tests_bad;
  logic hung;
  logic done;
  int  fail_count;

  sm_core dut (
    .clk              (clk),
    .reset            (reset),
    .clk_en           (clk_en),
    .rom_data         (rom_data),
    .rom_addr         (rom_addr),
    .input_k          (input_k),
    .output_shifter_s (output_shifter_s),
    .segment_l        (segment_l)
  );

  sm_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .stage       (dut.stage),
    .rom_addr    (rom_addr),
    .w           (output_shifter_s),
    .l           (segment_l),
    .input_k     (input_k),
    .instr_limit (n_instr),
    .done        (done),
    .fail_count  (fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ROM answers the current address
  // clk_en high about 3 cycles in 4
  always @(negedge clk) begin
    rom_data <= rom[rom_addr];
    clk_en <= ($random(en_seed) & 3) != 0;
  end

  //////////////////////////////////////////////////
  // Program building

  function automatic sm_core_pkg::pc_t step_addr(input sm_core_pkg::pc_t p);
    return {p[11:6], p[0] == p[1], p[5:1]};
  endfunction

  function automatic sm_core_pkg::nibble_t rnd4();
    return $random(seed);
  endfunction

  // Raw byte such as the second byte of LBL or TL
  task automatic emit(input sm_core_pkg::opcode_t b);
    rom[org] = b;
    org = step_addr(org);
  endtask

  task automatic emit_op(input sm_core_pkg::opcode_t b);
    emit(b);
    n_instr++;
  endtask

  task automatic new_program();
    logic [11:0] a;
    // Unused space holds in-page jumps
    for (int i = 0; i < 4096; i++) begin
      a = i;
      rom[i] = {2'b10, a[5:0] ^ a[11:6]};
    end
    org = sm_core_pkg::RESET_PC;
    n_instr = 0;
  endtask

  // Fill one RAM file with random data from Bl 0 up to F
  task automatic fill_ram_file(input logic [2:0] bm);
    emit_op(sm_isa_pkg::OP_LBL);
    emit({1'b0, bm, 4'h0});
    for (int i = 0; i < 16; i++) begin
      emit_op({sm_isa_pkg::PFX_LAX, rnd4()});
      emit_op({sm_isa_pkg::PFX_EXCI, 2'b00});
    end
    // Slot skipped on the Bl wrap
    emit_op(8'h00);
  endtask

  task automatic run_test(input string name);
    int cycles;
    int fails_before;
    fails_before = fail_count;
    input_k = rnd4();
    reset = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (!done && cycles < 4 * n_instr * 2) begin
      @(negedge clk);
      cycles++;
    end
    tests_run++;
    if (!done) begin
      $display("Timeout: test %s did not finish its %0d instructions", name, n_instr);
      hung = 1'b1;
    end else if (fail_count != fails_before) begin
      $display("test %s: %0d mismatches", name, fail_count - fails_before);
      tests_bad++;
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic reset_steps_test();
    new_program();
    for (int i = 0; i < 8; i++) emit_op(8'h00);
    run_test("reset_and_step");
  endtask

  task automatic arith_test();
    new_program();
    fill_ram_file(3'd0);
    emit_op({sm_isa_pkg::PFX_LB, rnd4() & 4'hC});
    emit_op({sm_isa_pkg::PFX_LAX, rnd4()});
    emit_op(8'h10);
    emit_op({sm_isa_pkg::PFX_LAX, rnd4()});
    emit_op(sm_isa_pkg::OP_ADD);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op({sm_isa_pkg::PFX_ADX, rnd4()});
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_RC);
    emit_op(sm_isa_pkg::OP_ADD11);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_SC);
    emit_op(sm_isa_pkg::OP_ROT);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_COMA);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_KTA);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_EXBLA);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_TC);
    emit_op(sm_isa_pkg::OP_ATL);
    // ADX with 0xA never skips, even on a carry out of F
    emit_op({sm_isa_pkg::PFX_LAX, 4'hF});
    emit_op({sm_isa_pkg::PFX_ADX, sm_isa_pkg::ADX_QUIRK});
    emit_op(sm_isa_pkg::OP_ATL);
    run_test("arith");
  endtask

  task automatic ram_b_test();
    new_program();
    fill_ram_file(3'd5);
    fill_ram_file(3'd0);
    fill_ram_file(3'd1);
    emit_op({sm_isa_pkg::PFX_LB, rnd4() & 4'hC});
    emit_op({sm_isa_pkg::PFX_SM, 2'(rnd4())});
    emit_op({sm_isa_pkg::PFX_RM, 2'(rnd4())});
    emit_op({sm_isa_pkg::PFX_TMI, 2'(rnd4())});
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(8'h18);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(8'h11);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(8'h14);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(8'h1C);
    emit_op(sm_isa_pkg::OP_TAM);
    emit_op(sm_isa_pkg::OP_ATL);
    // Bm is 1 here so SBM reads file 5 once
    emit_op(sm_isa_pkg::OP_SBM);
    emit_op(8'h18);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(8'h18);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_TABL);
    emit_op(sm_isa_pkg::OP_INCB);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_DECB);
    emit_op(sm_isa_pkg::OP_TAO);
    emit_op(sm_isa_pkg::OP_LBL);
    emit({4'h1, rnd4()});
    emit_op(8'h18);
    emit_op(sm_isa_pkg::OP_ATL);
    run_test("ram_and_b");
  endtask

  task automatic skip_test();
    new_program();
    // Only the first LAX of a chain runs
    emit_op({sm_isa_pkg::PFX_LAX, rnd4()});
    emit_op({sm_isa_pkg::PFX_LAX, rnd4()});
    emit_op({sm_isa_pkg::PFX_LAX, rnd4()});
    emit_op(sm_isa_pkg::OP_ATL);
    // Acc of zero makes the first TAO skip and the second run through
    emit_op({sm_isa_pkg::PFX_LAX, 4'h0});
    emit_op(sm_isa_pkg::OP_TAO);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_COMA);
    emit_op(sm_isa_pkg::OP_TAO);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_SC);
    emit_op(sm_isa_pkg::OP_TC);
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_RC);
    emit_op(sm_isa_pkg::OP_TC);
    emit_op(sm_isa_pkg::OP_ATL);
    run_test("skips");
  endtask

  task automatic flow_test();
    new_program();
    // TML to 0x485 with the return landing on the skipped slot
    emit_op(8'h7E);
    emit(8'h45);
    emit_op(8'h00);
    emit_op(8'hC3);
    emit_op(8'h75);
    emit(8'h8A);
    // TM table entry pointing at 0x111
    rom[12'h003] = 8'h11;
    org = 12'h485;
    emit_op({sm_isa_pkg::PFX_LAX, rnd4()});
    emit_op(sm_isa_pkg::OP_ATL);
    emit_op(sm_isa_pkg::OP_WS);
    emit_op(sm_isa_pkg::OP_RTN1);
    org = 12'h111;
    emit_op(sm_isa_pkg::OP_WR);
    emit_op(sm_isa_pkg::OP_RTN0);
    // TL target followed by T within the page
    org = 12'h94A;
    emit_op(8'hBC);
    org = 12'h97C;
    emit_op({sm_isa_pkg::PFX_LAX, 4'h9});
    emit_op(sm_isa_pkg::OP_ATPL);
    org = 12'h979;
    emit_op(sm_isa_pkg::OP_WS);
    run_test("control_flow");
  endtask

  task automatic shifter_test();
    new_program();
    for (int i = 0; i < 16; i++) begin
      emit_op(rnd4() & 1 ? sm_isa_pkg::OP_WS : sm_isa_pkg::OP_WR);
    end
    emit_op({sm_isa_pkg::PFX_LAX, rnd4()});
    emit_op(sm_isa_pkg::OP_ATL);
    run_test("w_shifter");
  endtask

  initial begin
    seed = 51546;
    reset = 1'b1;
    clk_en = 1'b0;
    rom_data = '0;
    input_k = '0;
    n_instr = 1;
    tests_run = 0;
    tests_bad = 0;
    hung = 1'b0;
    reset_steps_test();
    if (!hung) arith_test();
    if (!hung) ram_b_test();
    if (!hung) skip_test();
    if (!hung) flow_test();
    if (!hung) shifter_test();
    $display("%0d run, %0d with mismatches, %0d checks wrong", tests_run, tests_bad, fail_count);
    if (!hung && fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- sim/sm_checker.sv
`timescale 1ns/1ns

module sm_checker (
  input  logic                            clk,
  input  logic                            reset,
  input  sm_isa_pkg::stage_t              stage,
  input  sm_core_pkg::pc_t                rom_addr,
  input  logic [sm_core_pkg::W_WIDTH-1:0] w,
  input  sm_core_pkg::nibble_t            l,
  input  sm_core_pkg::nibble_t            input_k,
  input  int                              instr_limit,
  output logic                            done,
  output int                              fail_count
);

  // Software copy of the core state
  sm_core_pkg::pc_t       m_pc;
  sm_core_pkg::pc_t       m_s;
  sm_core_pkg::pc_t       m_r;
  sm_core_pkg::nibble_t   m_acc;
  logic                   m_c;
  logic [2:0]             m_bm;
  sm_core_pkg::nibble_t   m_bl;
  logic                   m_sbm;
  logic                   m_skip;
  logic                   m_lax;
  sm_core_pkg::nibble_t   m_ram [128];
  logic [7:0]             m_w;
  sm_core_pkg::nibble_t   m_l;

  sm_isa_pkg::stage_t prev_stage;
  logic               started;
  int                 count;

  initial begin
    fail_count = 0;
    done = 1'b0;
  end

  // Pl steps as a shift register, new top bit is Pl[0] XNOR Pl[1]
  function automatic sm_core_pkg::pc_t next_pc(input sm_core_pkg::pc_t p);
    return {p[11:6], p[0] == p[1], p[5:1]};
  endfunction

  function automatic sm_core_pkg::opcode_t rom_at(input sm_core_pkg::pc_t a);
    return tb_sm_core.rom[a];
  endfunction

  //////////////////////////////////////////////////
  // Reference model, one instruction per call

  function automatic void step_model(input sm_core_pkg::nibble_t k);
    sm_core_pkg::opcode_t op;
    sm_core_pkg::opcode_t b2;
    sm_core_pkg::pc_t     npc;
    logic [6:0]           a;
    sm_core_pkg::nibble_t m;
    sm_core_pkg::nibble_t t;
    logic [4:0]           sum;
    logic                 skip;
    logic                 lax;
    op = rom_at(m_pc);
    lax = op[7:4] == sm_isa_pkg::PFX_LAX;
    npc = next_pc(m_pc);
    // Skipped slot, only the PC moves
    if (m_skip || (m_lax && lax)) begin
      m_skip = 1'b0;
      m_lax = m_lax && lax;
      m_pc = npc;
      return;
    end
    a = {m_bm[2] | m_sbm, m_bm[1:0], m_bl};
    m = m_ram[a];
    m_sbm = op == sm_isa_pkg::OP_SBM;
    skip = 1'b0;
    if (op[7:6] == sm_isa_pkg::PFX_T) npc = {m_pc[11:6], op[5:0]};
    else if (op[7:6] == sm_isa_pkg::PFX_TM) begin
      // Table byte on page 0 picks the index page target
      m_r = m_s;
      m_s = npc;
      b2 = rom_at({6'b0, op[5:0]});
      npc = {b2[7:6], sm_core_pkg::IDX_PAGE, b2[5:0]};
    end else if (op == sm_isa_pkg::OP_RTN0 || op == sm_isa_pkg::OP_RTN1) begin
      npc = m_s;
      m_s = m_r;
      skip = op == sm_isa_pkg::OP_RTN1;
    end else if (op == sm_isa_pkg::OP_ATPL) npc = {m_pc[11:4], m_acc};
    else if (op == sm_isa_pkg::OP_LBL) begin
      b2 = rom_at(npc);
      m_bm = b2[6:4];
      m_bl = b2[3:0];
      npc = next_pc(npc);
    end else if (op[7:4] == sm_isa_pkg::PFX_TL) begin
      b2 = rom_at(npc);
      if (op[3:0] <= 4'hA) npc = {b2[7:6], op[3:0], b2[5:0]};
      else if (op[3:0] >= 4'hC) begin
        // Return address is past the second byte
        m_r = m_s;
        m_s = next_pc(npc);
        npc = {b2[7:6], 2'b00, op[1:0], b2[5:0]};
      end else npc = next_pc(npc);
    end else if (op[7:2] == sm_isa_pkg::PFX_RM) m_ram[a] = m & ~(4'b1 << op[1:0]);
    else if (op[7:2] == sm_isa_pkg::PFX_SM) m_ram[a] = m | (4'b1 << op[1:0]);
    else if (op == sm_isa_pkg::OP_ADD) m_acc = m_acc + m;
    else if (op == sm_isa_pkg::OP_ADD11) begin
      sum = m_acc + m + m_c;
      {m_c, m_acc} = sum;
      skip = sum[4];
    end else if (op == sm_isa_pkg::OP_COMA) m_acc = ~m_acc;
    else if (op == sm_isa_pkg::OP_EXBLA) begin
      t = m_acc;
      m_acc = m_bl;
      m_bl = t;
    end else if (op[7:4] == 4'h1) begin
      // EXC, EXCI, LDA, EXCD
      t = m_acc;
      m_acc = m;
      if (op[7:2] != sm_isa_pkg::PFX_LDA) m_ram[a] = t;
      m_bm[1:0] = m_bm[1:0] ^ op[1:0];
      if (op[7:2] == sm_isa_pkg::PFX_EXCI) begin
        skip = m_bl == 4'hF;
        m_bl = m_bl + 4'h1;
      end else if (op[7:2] == sm_isa_pkg::PFX_EXCD) begin
        skip = m_bl == 4'h0;
        m_bl = m_bl - 4'h1;
      end
    end else if (lax) m_acc = op[3:0];
    else if (op[7:4] == sm_isa_pkg::PFX_ADX) begin
      sum = m_acc + op[3:0];
      m_acc = sum[3:0];
      skip = sum[4] && op[3:0] != 4'hA;
    end else if (op[7:4] == sm_isa_pkg::PFX_LB) begin
      m_bm[1:0] = op[1:0];
      m_bl = {op[3] | op[2], op[3] | op[2], op[3:2]};
    end else if (op == sm_isa_pkg::OP_TC) skip = !m_c;
    else if (op == sm_isa_pkg::OP_TAM) skip = m_acc == m;
    else if (op[7:2] == sm_isa_pkg::PFX_TMI) skip = m[op[1:0]];
    else if (op == sm_isa_pkg::OP_TAO) skip = m_acc == 4'h0;
    else if (op == sm_isa_pkg::OP_TABL) skip = m_acc == m_bl;
    else if (op == sm_isa_pkg::OP_ATL) m_l = m_acc;
    else if (op == sm_isa_pkg::OP_WR) m_w = {m_w[6:0], 1'b0};
    else if (op == sm_isa_pkg::OP_WS) m_w = {m_w[6:0], 1'b1};
    else if (op == sm_isa_pkg::OP_INCB) begin
      skip = m_bl == 4'hF;
      m_bl = m_bl + 4'h1;
    end else if (op == sm_isa_pkg::OP_DECB) begin
      skip = m_bl == 4'h0;
      m_bl = m_bl - 4'h1;
    end else if (op == sm_isa_pkg::OP_RC) m_c = 1'b0;
    else if (op == sm_isa_pkg::OP_SC) m_c = 1'b1;
    else if (op == sm_isa_pkg::OP_KTA) m_acc = k;
    else if (op == sm_isa_pkg::OP_ROT) {m_acc, m_c} = {m_c, m_acc};
    m_skip = skip;
    m_lax = lax;
    m_pc = npc;
  endfunction

  task automatic compare_state();
    if (rom_addr !== m_pc) begin
      $display("Fail at %0t: rom_addr %h, expected %h", $time, rom_addr, m_pc);
      fail_count++;
    end
    if (w !== m_w) begin
      $display("Fail at %0t: W %b, expected %b", $time, w, m_w);
      fail_count++;
    end
    if (l !== m_l) begin
      $display("Fail at %0t: L %h, expected %h", $time, l, m_l);
      fail_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // Boundary tracking, values seen before the edge updates them

  always @(posedge clk) begin
    if (reset) begin
      m_pc = sm_core_pkg::RESET_PC;
      {m_s, m_r} = '0;
      {m_acc, m_c, m_bm, m_bl} = '0;
      {m_sbm, m_skip, m_lax} = '0;
      m_w = '0;
      m_l = '0;
      started = 1'b0;
      count = 0;
      done = 1'b0;
    end else if (!started) begin
      started = 1'b1;
      prev_stage = stage;
      if (stage != sm_isa_pkg::LOAD_PC) begin
        $display("Sequencer is not in LOAD_PC after reset");
        fail_count++;
      end
      compare_state();
    end else begin
      // Back in LOAD_PC means one instruction has finished
      if (stage == sm_isa_pkg::LOAD_PC && prev_stage != sm_isa_pkg::LOAD_PC && !done) begin
        step_model(input_k);
        count++;
        compare_state();
        if (count >= instr_limit) done = 1'b1;
      end
      prev_stage = stage;
    end
  end

endmodule

//--- src/sm_core.sv
`timescale 1ns/1ns

module sm_core (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              clk_en,
  input  sm_core_pkg::opcode_t              rom_data,
  output sm_core_pkg::pc_t                  rom_addr,
  input  sm_core_pkg::nibble_t              input_k,
  output logic [sm_core_pkg::W_WIDTH-1:0]   output_shifter_s,
  output sm_core_pkg::nibble_t              segment_l
);

  //////////////////////////////////////////////////
  // Internal nets

  sm_isa_pkg::stage_t    stage;
  sm_core_pkg::nibble_t  acc;
  logic                  skip_alu;
  logic                  skip_alu_valid;
  logic                  set_lax_skip;

  sm_core_pkg::ram_addr_t ram_addr;
  logic                   ram_wr;
  sm_core_pkg::nibble_t   ram_wr_data;
  sm_core_pkg::nibble_t   ram_q;

  //////////////////////////////////////////////////
  // Fetch side

  // PC goes straight out as the ROM address
  sm_sequencer u_sequencer (
    .clk            (clk),
    .reset          (reset),
    .clk_en         (clk_en),
    .opcode         (rom_data),
    .acc            (acc),
    .skip_alu       (skip_alu),
    .skip_alu_valid (skip_alu_valid),
    .set_lax_skip   (set_lax_skip),
    .stage          (stage),
    .pc             (rom_addr)
  );

  //////////////////////////////////////////////////
  // Processing

  sm_execute u_execute (
    .clk            (clk),
    .reset          (reset),
    .clk_en         (clk_en),
    .stage          (stage),
    .opcode         (rom_data),
    .ram_q          (ram_q),
    .input_k        (input_k),
    .acc            (acc),
    .ram_addr       (ram_addr),
    .ram_wr         (ram_wr),
    .ram_wr_data    (ram_wr_data),
    .skip_alu       (skip_alu),
    .skip_alu_valid (skip_alu_valid),
    .set_lax_skip   (set_lax_skip)
  );

  sm_ram u_ram (
    .clk  (clk),
    .addr (ram_addr),
    .wren (ram_wr),
    .data (ram_wr_data),
    .q    (ram_q)
  );

  //////////////////////////////////////////////////
  // Output side

  sm_port_unit u_port_unit (
    .clk              (clk),
    .reset            (reset),
    .clk_en           (clk_en),
    .stage            (stage),
    .opcode           (rom_data),
    .acc              (acc),
    .output_shifter_s (output_shifter_s),
    .segment_l        (segment_l)
  );

endmodule

//--- src/sm_port_unit.sv
`timescale 1ns/1ns

module sm_port_unit (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              clk_en,
  input  sm_isa_pkg::stage_t                stage,
  input  sm_core_pkg::opcode_t              opcode,
  input  sm_core_pkg::nibble_t              acc,
  output logic [sm_core_pkg::W_WIDTH-1:0]   output_shifter_s,
  output sm_core_pkg::nibble_t              segment_l
);

  logic perf;

  // Port opcodes all act in the first execute stage
  assign perf = clk_en && (stage == sm_isa_pkg::PERF_1);

  always_ff @(posedge clk) begin
    if (reset) begin
      output_shifter_s <= '0;
      segment_l <= '0;
    end else if (perf) begin
      case (opcode)
        // W shifts toward the top, new bit enters at bit 0
        sm_isa_pkg::OP_WR: output_shifter_s <= {output_shifter_s[sm_core_pkg::W_WIDTH-2:0], 1'b0};
        sm_isa_pkg::OP_WS: output_shifter_s <= {output_shifter_s[sm_core_pkg::W_WIDTH-2:0], 1'b1};
        // L latch follows Acc
        sm_isa_pkg::OP_ATL: segment_l <= acc;
        default: begin
        end
      endcase
    end
  end

endmodule

//--- execute/sm_execute.sv
`timescale 1ns/1ns

module sm_execute (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clk_en,
  input  sm_isa_pkg::stage_t     stage,
  input  sm_core_pkg::opcode_t   opcode,
  input  sm_core_pkg::nibble_t   ram_q,
  input  sm_core_pkg::nibble_t   input_k,
  output sm_core_pkg::nibble_t   acc,
  output sm_core_pkg::ram_addr_t ram_addr,
  output logic                   ram_wr,
  output sm_core_pkg::nibble_t   ram_wr_data,
  output logic                   skip_alu,
  output logic                   skip_alu_valid,
  output logic                   set_lax_skip
);

  logic                 carry;
  sm_core_pkg::bm_t     bm;
  sm_core_pkg::nibble_t bl;

  // B change held back until the RAM write has used the old address
  logic                 b_pending;
  logic [1:0]           pend_bm_lo;
  sm_core_pkg::nibble_t pend_bl;

  // SBM forces Bm[2] high for the next executed instruction
  logic sbm_active;
  logic sbm_used;
  logic lbl_pending;

  logic [4:0]           add11_sum;
  logic [4:0]           adx_sum;
  sm_core_pkg::nibble_t bit_mask;
  logic                 is_xfer;
  logic                 lb_or;

  assign add11_sum = {1'b0, acc} + {1'b0, ram_q} + {4'b0, carry};
  assign adx_sum = {1'b0, acc} + {1'b0, opcode[3:0]};
  assign bit_mask = 4'b0001 << opcode[1:0];
  // EXC, EXCI, LDA and EXCD share bits 7..4
  assign is_xfer = opcode[7:4] == sm_isa_pkg::PFX_EXC[5:2];
  assign lb_or = opcode[3] | opcode[2];

  assign ram_addr = {bm[2] | sbm_active, bm[1:0], bl};
  assign set_lax_skip = (stage == sm_isa_pkg::PERF_1) && (opcode[7:4] == sm_isa_pkg::PFX_LAX);

  //////////////////////////////////////////////////
  // Skip conditions, taken by the sequencer in PERF_1

  always_comb begin
    skip_alu = 1'b0;
    skip_alu_valid = stage == sm_isa_pkg::PERF_1;
    if (opcode == sm_isa_pkg::OP_ADD11) skip_alu = add11_sum[4];
    else if (opcode[7:4] == sm_isa_pkg::PFX_ADX)
      skip_alu = adx_sum[4] && (opcode[3:0] != sm_isa_pkg::ADX_QUIRK);
    else if (opcode == sm_isa_pkg::OP_TC) skip_alu = !carry;
    else if (opcode == sm_isa_pkg::OP_TAM) skip_alu = acc == ram_q;
    else if (opcode[7:2] == sm_isa_pkg::PFX_TMI) skip_alu = ram_q[opcode[1:0]];
    else if (opcode == sm_isa_pkg::OP_TAO) skip_alu = acc == 4'h0;
    else if (opcode == sm_isa_pkg::OP_TABL) skip_alu = acc == bl;
    // Bl wraps on the step
    else if (opcode == sm_isa_pkg::OP_INCB || opcode[7:2] == sm_isa_pkg::PFX_EXCI)
      skip_alu = bl == 4'hF;
    else if (opcode == sm_isa_pkg::OP_DECB || opcode[7:2] == sm_isa_pkg::PFX_EXCD)
      skip_alu = bl == 4'h0;
    else skip_alu_valid = 1'b0;
  end

  //////////////////////////////////////////////////
  // Acc, carry, B and RAM write path

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
      carry <= 1'b0;
      bm <= '0;
      bl <= '0;
      b_pending <= 1'b0;
      sbm_active <= 1'b0;
      sbm_used <= 1'b0;
      lbl_pending <= 1'b0;
      ram_wr <= 1'b0;
    end else if (clk_en) begin
      ram_wr <= 1'b0;
      case (stage)
        sm_isa_pkg::LOAD_PC: begin
          if (b_pending) begin
            {bm[1:0], bl} <= {pend_bm_lo, pend_bl};
          end
          b_pending <= 1'b0;
          // Override has served one instruction
          if (sbm_used) begin
            sbm_active <= 1'b0;
            sbm_used <= 1'b0;
          end
        end
        sm_isa_pkg::PERF_1: begin
          sbm_used <= sbm_active;
          lbl_pending <= opcode == sm_isa_pkg::OP_LBL;
          if (opcode == sm_isa_pkg::OP_SBM) sbm_active <= 1'b1;
          else if (opcode[7:2] == sm_isa_pkg::PFX_RM) begin
            ram_wr_data <= ram_q & ~bit_mask;
            ram_wr <= 1'b1;
          end else if (opcode[7:2] == sm_isa_pkg::PFX_SM) begin
            ram_wr_data <= ram_q | bit_mask;
            ram_wr <= 1'b1;
          end else if (opcode == sm_isa_pkg::OP_ADD) acc <= acc + ram_q;
          else if (opcode == sm_isa_pkg::OP_ADD11) {carry, acc} <= add11_sum;
          else if (opcode == sm_isa_pkg::OP_COMA) acc <= ~acc;
          else if (opcode == sm_isa_pkg::OP_EXBLA) begin
            acc <= bl;
            bl <= acc;
          end else if (is_xfer) begin
            // LDA loads without writing back
            acc <= ram_q;
            ram_wr_data <= acc;
            ram_wr <= opcode[7:2] != sm_isa_pkg::PFX_LDA;
            pend_bm_lo <= bm[1:0] ^ opcode[1:0];
            if (opcode[7:2] == sm_isa_pkg::PFX_EXCI) pend_bl <= bl + 4'h1;
            else if (opcode[7:2] == sm_isa_pkg::PFX_EXCD) pend_bl <= bl - 4'h1;
            else pend_bl <= bl;
            b_pending <= 1'b1;
          end else if (opcode[7:4] == sm_isa_pkg::PFX_LAX) acc <= opcode[3:0];
          else if (opcode[7:4] == sm_isa_pkg::PFX_ADX) acc <= adx_sum[3:0];
          else if (opcode[7:4] == sm_isa_pkg::PFX_LB) begin
            bl <= {lb_or, lb_or, opcode[3:2]};
            bm[1:0] <= opcode[1:0];
          end else if (opcode == sm_isa_pkg::OP_INCB || opcode == sm_isa_pkg::OP_DECB) begin
            pend_bm_lo <= bm[1:0];
            pend_bl <= (opcode == sm_isa_pkg::OP_INCB) ? bl + 4'h1 : bl - 4'h1;
            b_pending <= 1'b1;
          end else if (opcode == sm_isa_pkg::OP_RC) carry <= 1'b0;
          else if (opcode == sm_isa_pkg::OP_SC) carry <= 1'b1;
          else if (opcode == sm_isa_pkg::OP_KTA) acc <= input_k;
          // Rotate right through carry
          else if (opcode == sm_isa_pkg::OP_ROT) {acc, carry} <= {carry, acc};
        end
        sm_isa_pkg::PERF_3: begin
          // LBL second byte, bit 7 unused
          if (lbl_pending) begin
            bm <= opcode[6:4];
            bl <= opcode[3:0];
          end
          lbl_pending <= 1'b0;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

//--- sequencer/sm_sequencer.sv
`timescale 1ns/1ns

module sm_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 clk_en,
  input  sm_core_pkg::opcode_t opcode,
  input  sm_core_pkg::nibble_t acc,
  input  logic                 skip_alu,
  input  logic                 skip_alu_valid,
  input  logic                 set_lax_skip,
  output sm_isa_pkg::stage_t   stage,
  output sm_core_pkg::pc_t     pc
);

  // Two-level return stack, S on top
  sm_core_pkg::pc_t     stack_s;
  sm_core_pkg::pc_t     stack_r;
  // First byte of a two-byte instruction
  sm_core_pkg::opcode_t last_opcode;

  logic skip_next;
  // Set by LAX, holds while LAX keeps following
  logic skip_if_lax;

  sm_core_pkg::pl_t pl_inc;
  sm_core_pkg::pc_t pc_inc;

  logic is_lax;
  logic is_two_byte;
  logic is_t;
  logic is_tm;
  logic is_tl;
  logic is_tml;

  // Pl is a shift counter: feedback bit is Pl[0] XNOR Pl[1]
  assign pl_inc = {pc[0] == pc[1], pc[5:1]};
  // Pu and Pm never change on a step
  assign pc_inc = {pc[11:6], pl_inc};

  assign is_lax = opcode[7:4] == sm_isa_pkg::PFX_LAX;
  assign is_two_byte = (opcode == sm_isa_pkg::OP_LBL) || (opcode[7:4] == sm_isa_pkg::PFX_TL);
  assign is_t = opcode[7:6] == sm_isa_pkg::PFX_T;
  assign is_tm = opcode[7:6] == sm_isa_pkg::PFX_TM;
  // TL or TML, decided from the saved first byte
  assign is_tl = (last_opcode[7:4] == sm_isa_pkg::PFX_TL) &&
                 (last_opcode[3:0] <= sm_isa_pkg::TL_LAST_PM);
  assign is_tml = (last_opcode[7:4] == sm_isa_pkg::PFX_TL) &&
                  (last_opcode[3:0] >= sm_isa_pkg::TML_FIRST_PM);

  //////////////////////////////////////////////////
  // Stage machine and program counter

  always_ff @(posedge clk) begin
    if (reset) begin
      stage <= sm_isa_pkg::LOAD_PC;
      pc <= sm_core_pkg::RESET_PC;
      stack_s <= '0;
      stack_r <= '0;
      skip_next <= 1'b0;
      skip_if_lax <= 1'b0;
    end else if (clk_en) begin
      case (stage)
        sm_isa_pkg::LOAD_PC: begin
          // Opcode at PC is visible here, decide whether to run it
          if (skip_next || (skip_if_lax && is_lax)) begin
            stage <= sm_isa_pkg::SKIP;
          end else begin
            stage <= sm_isa_pkg::PERF_1;
          end
          skip_next <= 1'b0;
          skip_if_lax <= skip_if_lax && is_lax;
        end
        sm_isa_pkg::PERF_1: begin
          last_opcode <= opcode;
          if (skip_alu_valid) begin
            skip_next <= skip_alu;
          end
          if (set_lax_skip) begin
            skip_if_lax <= 1'b1;
          end
          if (is_t) begin
            // Jump within the current page
            pc[5:0] <= opcode[5:0];
          end else if (is_tm) begin
            // Call through the table on page 0
            stack_r <= stack_s;
            stack_s <= pc_inc;
            pc <= {6'b0, opcode[5:0]};
          end else if (opcode == sm_isa_pkg::OP_RTN0 || opcode == sm_isa_pkg::OP_RTN1) begin
            pc <= stack_s;
            stack_s <= stack_r;
            skip_next <= opcode == sm_isa_pkg::OP_RTN1;
          end else if (opcode == sm_isa_pkg::OP_ATPL) begin
            // Upper two Pl bits stay those of this instruction
            pc[5:0] <= {pc[5:4], acc};
          end else begin
            pc <= pc_inc;
          end
          if (is_tm) begin
            stage <= sm_isa_pkg::IDX_FETCH;
          end else if (is_two_byte) begin
            stage <= sm_isa_pkg::LOAD_2;
          end else begin
            stage <= sm_isa_pkg::LOAD_PC;
          end
        end
        // Second byte settles on the ROM bus
        sm_isa_pkg::LOAD_2: stage <= sm_isa_pkg::PERF_3;
        sm_isa_pkg::PERF_3: begin
          if (is_tl) begin
            pc <= {opcode[7:6], last_opcode[3:0], opcode[5:0]};
          end else if (is_tml) begin
            // Return lands after the second byte
            stack_r <= stack_s;
            stack_s <= pc_inc;
            pc <= {opcode[7:6], 2'b00, last_opcode[1:0], opcode[5:0]};
          end else begin
            // LBL, and the unused 0x7B
            pc <= pc_inc;
          end
          stage <= sm_isa_pkg::LOAD_PC;
        end
        sm_isa_pkg::IDX_FETCH: stage <= sm_isa_pkg::IDX_PERF;
        sm_isa_pkg::IDX_PERF: begin
          // Table byte selects Pu and Pl on the index page
          pc <= {opcode[7:6], sm_core_pkg::IDX_PAGE, opcode[5:0]};
          stage <= sm_isa_pkg::LOAD_PC;
        end
        sm_isa_pkg::SKIP: begin
          pc <= pc_inc;
          stage <= sm_isa_pkg::LOAD_PC;
        end
        default: stage <= sm_isa_pkg::LOAD_PC;
      endcase
    end
  end

endmodule

//--- src/sm_ram.sv
`timescale 1ns/1ns

module sm_ram (
  input  logic                   clk,
  input  sm_core_pkg::ram_addr_t addr,
  input  logic                   wren,
  input  sm_core_pkg::nibble_t   data,
  output sm_core_pkg::nibble_t   q
);

  // 8 files of 16 nibbles, addressed {Bm, Bl}
  sm_core_pkg::nibble_t mem [sm_core_pkg::RAM_DEPTH];

  // Write lands on the edge that commits the instruction
  always_ff @(posedge clk) begin
    if (wren) begin
      mem[addr] <= data;
    end
  end

  // Read is combinational so PERF_1 sees the word at once
  assign q = mem[addr];

endmodule

//--- common/sm_isa_pkg.sv
package sm_isa_pkg;

  // Sequencer stages, one per enabled edge
  typedef enum logic [2:0] {
    LOAD_PC,
    PERF_1,
    LOAD_2,
    PERF_3,
    IDX_FETCH,
    IDX_PERF,
    SKIP
  } stage_t;

  //////////////////////////////////////////////////
  // Single opcodes

  localparam logic [7:0] OP_SBM   = 8'h02;
  localparam logic [7:0] OP_ATPL  = 8'h03;
  localparam logic [7:0] OP_ADD   = 8'h08;
  localparam logic [7:0] OP_ADD11 = 8'h09;
  localparam logic [7:0] OP_COMA  = 8'h0A;
  localparam logic [7:0] OP_EXBLA = 8'h0B;
  localparam logic [7:0] OP_TC    = 8'h52;
  localparam logic [7:0] OP_TAM   = 8'h53;
  localparam logic [7:0] OP_ATL   = 8'h59;
  localparam logic [7:0] OP_TAO   = 8'h5A;
  localparam logic [7:0] OP_TABL  = 8'h5B;
  localparam logic [7:0] OP_LBL   = 8'h5F;
  localparam logic [7:0] OP_WR    = 8'h62;
  localparam logic [7:0] OP_WS    = 8'h63;
  localparam logic [7:0] OP_INCB  = 8'h64;
  localparam logic [7:0] OP_RC    = 8'h66;
  localparam logic [7:0] OP_SC    = 8'h67;
  localparam logic [7:0] OP_KTA   = 8'h6A;
  localparam logic [7:0] OP_ROT   = 8'h6B;
  localparam logic [7:0] OP_DECB  = 8'h6C;
  localparam logic [7:0] OP_RTN0  = 8'h6E;
  localparam logic [7:0] OP_RTN1  = 8'h6F;

  //////////////////////////////////////////////////
  // Opcode groups, compared against the upper bits

  // Bits 7..2, low two bits are a bit index or Bm mask
  localparam logic [5:0] PFX_RM   = 6'b0000_01;
  localparam logic [5:0] PFX_SM   = 6'b0000_11;
  localparam logic [5:0] PFX_EXC  = 6'b0001_00;
  localparam logic [5:0] PFX_EXCI = 6'b0001_01;
  localparam logic [5:0] PFX_LDA  = 6'b0001_10;
  localparam logic [5:0] PFX_EXCD = 6'b0001_11;
  localparam logic [5:0] PFX_TMI  = 6'b0101_01;
  // Bits 7..4, low nibble is an immediate
  localparam logic [3:0] PFX_LAX  = 4'h2;
  localparam logic [3:0] PFX_ADX  = 4'h3;
  localparam logic [3:0] PFX_LB   = 4'h4;
  localparam logic [3:0] PFX_TL   = 4'h7;
  // Bits 7..6, low six bits are a Pl target
  localparam logic [1:0] PFX_T    = 2'b10;
  localparam logic [1:0] PFX_TM   = 2'b11;

  // TL covers 0x70-0x7A, TML 0x7C-0x7F
  localparam logic [3:0] TL_LAST_PM   = 4'hA;
  localparam logic [3:0] TML_FIRST_PM = 4'hC;
  // ADX never skips with this immediate
  localparam logic [3:0] ADX_QUIRK    = 4'hA;

endpackage

//--- common/sm_core_pkg.sv
package sm_core_pkg;

  //////////////////////////////////////////////////
  // Data and address widths

  // One data word of the core (Acc, RAM, Bl, K, L)
  typedef logic [3:0] nibble_t;

  // One byte fetched from the program ROM
  typedef logic [7:0] opcode_t;

  // Program address as {Pu[1:0], Pm[3:0], Pl[5:0]}
  typedef logic [11:0] pc_t;

  // Offset within a page, stepped by the feedback counter
  typedef logic [5:0] pl_t;

  // RAM file select
  typedef logic [2:0] bm_t;

  // RAM address as {Bm[2:0], Bl[3:0]}
  typedef logic [6:0] ram_addr_t;

  //////////////////////////////////////////////////
  // Fixed values

  // Page 3_7, offset 0
  localparam pc_t RESET_PC = 12'hDC0;

  // Pm of the second jump taken by TM
  localparam logic [3:0] IDX_PAGE = 4'h4;

  localparam int W_WIDTH = 8;
  localparam int RAM_DEPTH = 128;

endpackage
